// File: dv/switch_patterns.txt
# columns: source port, destination port, data word in hex (source port in the top nibble)
# first twelve lines are the burst from port 0 to port 3
0 3 03000001
0 3 03000002
0 3 03000003
0 3 03000004
0 3 03000005
0 3 03000006
0 3 03000007
0 3 03000008
0 3 03000009
0 3 0300000a
0 3 0300000b
0 3 0300000c
1 0 10000001
1 2 10000002
2 1 20000003
2 0 20000004
3 1 30000005
3 2 30000006
1 1 10000007
2 2 20000008
3 0 30000009
0 1 00000021

// File: tb.f
source/mem_pkg.sv
source/switch_pkg.sv
source/port_writer.sv
source/buffer_arbiter.sv
source/block_store.sv
source/port_reader.sv
source/switch_core.sv
dv/switch_assertions.sv
dv/switch_tb.sv

// File: dv/switch_tb.sv
// switch slice testbench with pattern stimulus, credit sink, scoreboard and watchdog

`timescale 1ns/100ps

module switch_tb;
    import switch_pkg::*;
    import mem_pkg::*;

    localparam int MAX_PAT = 64;
    // egress port blocked during the burst, and the source of the burst
    localparam int HOLD_PORT = 3;
    localparam int BURST_SRC = 0;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid   [NUM_PORTS-1:0];
    logic [PORT_W-1:0]     in_dest    [NUM_PORTS-1:0];
    logic [BLOCK_BITS-1:0] in_data    [NUM_PORTS-1:0];
    logic                  out_credit [NUM_PORTS-1:0];
    logic                  in_credit  [NUM_PORTS-1:0];
    logic                  out_valid  [NUM_PORTS-1:0];
    logic [BLOCK_BITS-1:0] out_data   [NUM_PORTS-1:0];

    int                    pat_src  [MAX_PAT];
    int                    pat_dst  [MAX_PAT];
    logic [BLOCK_BITS-1:0] pat_data [MAX_PAT];
    int                    src_lines [NUM_PORTS][MAX_PAT];
    int                    next_pos  [NUM_PORTS][NUM_PORTS];
    int src_len [NUM_PORTS];
    int sent [NUM_PORTS];
    int src_credits [NUM_PORTS];
    int credit_pulses [NUM_PORTS];
    int rx_count [NUM_PORTS];
    int credits_given [NUM_PORTS];
    int owed [NUM_PORTS];
    int delay [NUM_PORTS];
    int n_pat;
    int rx_total;
    int hold_credits;
    int stall;
    int data_errors;
    int flow_errors;
    logic        hold;
    logic [31:0] lfsr;

    // assertion failures of the checkers bound into the readers
    int reader_fails [NUM_PORTS];

    switch_core dut0 (
        .clk, .rst_n,
        .in_valid_i(in_valid), .in_dest_i(in_dest), .in_data_i(in_data),
        .out_credit_i(out_credit), .in_credit_o(in_credit),
        .out_valid_o(out_valid), .out_data_o(out_data)
    );

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_fails
        assign reader_fails[g] = dut0.g_port[g].reader.reader_checks.fail_count;
    end

    function automatic logic [31:0] galois_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function int random_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = galois_step(lfsr);
        end
        return v;
    endfunction

    function automatic int next_line(int s, int d, int from);
        for (int i = from; i < n_pat; i++)
            if (pat_src[i] == s && pat_dst[i] == d)
                return i;
        return -1;
    endfunction

    function automatic int assertion_failures();
        int n;
        n = dut0.store.store_checks.fail_count;
        for (int p = 0; p < NUM_PORTS; p++)
            n += reader_fails[p];
        return n;
    endfunction

    task automatic check_block(int p, logic [BLOCK_BITS-1:0] w);
        int s;
        int idx;
        s = int'(w[BLOCK_BITS-1 -: 4]);
        rx_count[p]++;
        rx_total++;
        if (rx_count[p] > OUT_CREDITS + credits_given[p]) begin
            $display("FAILED egress_backpressure port %0d: expected at most %0d, actual %0d",
                     p, OUT_CREDITS + credits_given[p], rx_count[p]);
            flow_errors++;
        end
        idx = (s < NUM_PORTS) ? next_line(s, p, next_pos[s][p]) : -1;
        if (idx < 0) begin
            $display("port %0d delivered block %h that was not expected there", p, w);
            data_errors++;
        end else begin
            if (pat_data[idx] != w) begin
                $display("FAILED delivery_order port %0d: expected %h, actual %h",
                         p, pat_data[idx], w);
                data_errors++;
            end
            next_pos[s][p] = idx + 1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // source side, one block per held credit
                if (in_credit[p]) begin
                    src_credits[p]++;
                    credit_pulses[p]++;
                end
                if (src_credits[p] > 0 && sent[p] < src_len[p]) begin
                    in_valid[p] <= 1'b1;
                    in_dest[p]  <= PORT_W'(pat_dst[src_lines[p][sent[p]]]);
                    in_data[p]  <= pat_data[src_lines[p][sent[p]]];
                    src_credits[p]--;
                    sent[p]++;
                end else begin
                    in_valid[p] <= 1'b0;
                end
                // sink side, credits return after a random delay
                if (out_valid[p]) begin
                    check_block(p, out_data[p]);
                    if (owed[p] == 0)
                        delay[p] = random_bits(3);
                    owed[p]++;
                end
                if (owed[p] > 0 && !(hold && p == HOLD_PORT) && delay[p] == 0) begin
                    out_credit[p] <= 1'b1;
                    credits_given[p]++;
                    owed[p]--;
                    delay[p] = random_bits(3);
                end else begin
                    out_credit[p] <= 1'b0;
                    if (delay[p] > 0)
                        delay[p]--;
                end
            end
            // release the blocked sink once the burst source has stalled
            if (hold) begin
                if (in_credit[BURST_SRC]) begin
                    stall = 0;
                    hold_credits++;
                end else begin
                    stall++;
                end
                if (stall == 80) begin
                    if (hold_credits > NUM_BLOCKS + OUT_CREDITS) begin
                        $display("FAILED exhaustion port %0d: expected at most %0d, actual %0d",
                                 BURST_SRC, NUM_BLOCKS + OUT_CREDITS, hold_credits);
                        flow_errors++;
                    end
                    if (hold_credits >= src_len[BURST_SRC]) begin
                        $display("burst source credits never stopped while port 3 was blocked");
                        flow_errors++;
                    end
                    hold = 1'b0;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          s;
        int          d;
        int          assert_errors;
        logic [31:0] w;
        string       line;
        rst_n = 1'b0;
        hold  = 1'b1;
        lfsr  = 32'd68826;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_valid[p]    = 1'b0;
            in_dest[p]     = '0;
            in_data[p]     = '0;
            out_credit[p]  = 1'b0;
            src_credits[p] = IN_FIFO_DEPTH;
        end
        fd = $fopen("dv/switch_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file dv/switch_patterns.txt could not be opened");
            flow_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line[0] != "#" && n_pat < MAX_PAT &&
                    $sscanf(line, "%d %d %h", s, d, w) == 3 &&
                    s < NUM_PORTS && d < NUM_PORTS) begin
                    pat_src[n_pat]  = s;
                    pat_dst[n_pat]  = d;
                    pat_data[n_pat] = w;
                    src_lines[s][src_len[s]] = n_pat;
                    src_len[s]++;
                    n_pat++;
                end
            end
            $fclose(fd);
        end
        if (n_pat == 0) begin
            $display("no pattern lines were read");
            flow_errors++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (rx_total < n_pat)
            @(posedge clk);
        repeat (4) @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (credit_pulses[p] != src_len[p]) begin
                $display("FAILED ingress_credits port %0d: expected %0d, actual %0d",
                         p, src_len[p], credit_pulses[p]);
                flow_errors++;
            end
            if (src_credits[p] != IN_FIFO_DEPTH) begin
                $display("FAILED ingress_credits_final port %0d: expected %0d, actual %0d",
                         p, IN_FIFO_DEPTH, src_credits[p]);
                flow_errors++;
            end
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (next_line(p, q, next_pos[p][q]) >= 0) begin
                    $display("a block from source %0d never reached port %0d", p, q);
                    data_errors++;
                end
            end
        end
        assert_errors = assertion_failures();
        $display("errors: data %0d, flow %0d, assertion %0d",
                 data_errors, flow_errors, assert_errors);
        if (data_errors + flow_errors + assert_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // watchdog scaled by the pattern count
    initial begin
        wait (rst_n === 1'b1);
        repeat (n_pat * NUM_PORTS * 20) @(posedge clk);
        $display("timeout: only %0d of %0d blocks were delivered", rx_total, n_pat);
        $display("errors: data %0d, flow %0d, assertion %0d",
                 data_errors, flow_errors, assertion_failures());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: dv/switch_assertions.sv
// bounded counter checks for egress credits and the block free list, with their binds

`timescale 1ns/100ps

module switch_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       take_i,
    input logic       give_i,
    input logic [7:0] level_i,
    input logic [7:0] limit_i
);

    // number of failed assertions in this instance
    int fail_count;

    // level stays inside its range
    level_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        level_i <= limit_i)
        else begin
            $error("counter level above its limit");
            fail_count++;
        end

    // no read is granted without a credit, no index is allocated from an empty list
    no_take_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        take_i |-> level_i != 0)
        else begin
            $error("counter taken while empty");
            fail_count++;
        end

    // nothing is given back to a full counter
    no_give_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (give_i && !take_i) |-> level_i < limit_i)
        else begin
            $error("counter given while full");
            fail_count++;
        end

endmodule

bind port_reader switch_assertions reader_checks (
    .clk, .rst_n,
    .take_i(rd_gnt_i), .give_i(out_credit_i),
    .level_i(8'(credits)), .limit_i(8'(switch_pkg::OUT_CREDITS))
);

bind block_store switch_assertions store_checks (
    .clk, .rst_n,
    .take_i(alloc_gnt_o), .give_i(re_i),
    .level_i(8'(free_cnt)), .limit_i(8'(mem_pkg::NUM_BLOCKS))
);

// File: source/switch_core.sv
// switch slice top level with four writers, four readers, arbiter and block store

`timescale 1ns/100ps

module switch_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid_i   [switch_pkg::NUM_PORTS-1:0],
    input  logic [switch_pkg::PORT_W-1:0]  in_dest_i    [switch_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::BLOCK_BITS-1:0] in_data_i    [switch_pkg::NUM_PORTS-1:0],
    input  logic                           out_credit_i [switch_pkg::NUM_PORTS-1:0],
    output logic                           in_credit_o  [switch_pkg::NUM_PORTS-1:0],
    output logic                           out_valid_o  [switch_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::BLOCK_BITS-1:0] out_data_o   [switch_pkg::NUM_PORTS-1:0]
);
    import switch_pkg::*;
    import mem_pkg::*;

    // writer side
    logic                  alloc_req [NUM_PORTS-1:0];
    logic                  alloc_gnt [NUM_PORTS-1:0];
    logic [ADDR_W-1:0]     alloc_idx [NUM_PORTS-1:0];
    logic                  wr_gnt    [NUM_PORTS-1:0];
    logic                  wr_en     [NUM_PORTS-1:0];
    logic [ADDR_W-1:0]     wr_addr   [NUM_PORTS-1:0];
    logic [PORT_W-1:0]     wr_dest   [NUM_PORTS-1:0];
    logic [BLOCK_BITS-1:0] wr_data   [NUM_PORTS-1:0];
    // reader side
    logic                  rd_req    [NUM_PORTS-1:0];
    logic [ADDR_W-1:0]     rd_addr   [NUM_PORTS-1:0];
    logic                  rd_gnt    [NUM_PORTS-1:0];
    logic                  rd_valid  [NUM_PORTS-1:0];
    logic [BLOCK_BITS-1:0] rd_data   [NUM_PORTS-1:0];
    logic                  enq       [NUM_PORTS-1:0];
    logic [ADDR_W-1:0]     enq_idx   [NUM_PORTS-1:0];
    // store side
    logic                  st_alloc_req, st_alloc_gnt, st_we, st_re, st_rvalid;
    logic [ADDR_W-1:0]     st_alloc_idx, st_waddr, st_raddr;
    logic [BLOCK_BITS-1:0] st_wdata, st_rdata;

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        port_writer writer (
            .clk, .rst_n,
            .in_valid_i(in_valid_i[g]), .in_dest_i(in_dest_i[g]), .in_data_i(in_data_i[g]),
            .alloc_gnt_i(alloc_gnt[g]), .alloc_idx_i(alloc_idx[g]), .wr_gnt_i(wr_gnt[g]),
            .in_credit_o(in_credit_o[g]), .alloc_req_o(alloc_req[g]), .wr_en_o(wr_en[g]),
            .wr_addr_o(wr_addr[g]), .wr_dest_o(wr_dest[g]), .wr_data_o(wr_data[g])
        );
        port_reader reader (
            .clk, .rst_n,
            .enq_i(enq[g]), .enq_idx_i(enq_idx[g]), .rd_gnt_i(rd_gnt[g]),
            .rd_valid_i(rd_valid[g]), .rd_data_i(rd_data[g]),
            .out_credit_i(out_credit_i[g]), .rd_req_o(rd_req[g]), .rd_addr_o(rd_addr[g]),
            .out_valid_o(out_valid_o[g]), .out_data_o(out_data_o[g])
        );
    end

    buffer_arbiter arb (
        .clk, .rst_n,
        .alloc_req_i(alloc_req), .wr_en_i(wr_en), .wr_addr_i(wr_addr),
        .wr_dest_i(wr_dest), .wr_data_i(wr_data),
        .alloc_gnt_o(alloc_gnt), .alloc_idx_o(alloc_idx), .wr_gnt_o(wr_gnt),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt),
        .rd_valid_o(rd_valid), .rd_data_o(rd_data), .enq_o(enq), .enq_idx_o(enq_idx),
        .st_alloc_req_o(st_alloc_req), .st_we_o(st_we), .st_waddr_o(st_waddr),
        .st_wdata_o(st_wdata), .st_re_o(st_re), .st_raddr_o(st_raddr),
        .st_alloc_gnt_i(st_alloc_gnt), .st_alloc_idx_i(st_alloc_idx),
        .st_rvalid_i(st_rvalid), .st_rdata_i(st_rdata)
    );

    block_store store (
        .clk, .rst_n,
        .alloc_req_i(st_alloc_req), .we_i(st_we), .waddr_i(st_waddr), .wdata_i(st_wdata),
        .re_i(st_re), .raddr_i(st_raddr),
        .alloc_gnt_o(st_alloc_gnt), .alloc_idx_o(st_alloc_idx),
        .rvalid_o(st_rvalid), .rdata_o(st_rdata)
    );

endmodule

// File: source/port_reader.sv
// per-port descriptor queue, egress credit count, read issue and output register

`timescale 1ns/100ps

module port_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enq_i,
    input  logic [mem_pkg::ADDR_W-1:0]     enq_idx_i,
    input  logic                           rd_gnt_i,
    input  logic                           rd_valid_i,
    input  logic [mem_pkg::BLOCK_BITS-1:0] rd_data_i,
    input  logic                           out_credit_i,
    output logic                           rd_req_o,
    output logic [mem_pkg::ADDR_W-1:0]     rd_addr_o,
    output logic                           out_valid_o,
    output logic [mem_pkg::BLOCK_BITS-1:0] out_data_o
);
    import switch_pkg::*;
    import mem_pkg::*;

    // one entry per block, so the queue never overflows
    logic [ADDR_W-1:0] queue [NUM_BLOCKS];
    logic [ADDR_W-1:0] qwptr;
    logic [ADDR_W-1:0] qrptr;
    logic [ADDR_W:0]   qcount;

    logic [$clog2(OUT_CREDITS+1)-1:0] credits;

    assign rd_req_o  = (qcount != 0) && (credits != 0);
    assign rd_addr_o = queue[qrptr];

    always_ff @(posedge clk) begin
        if (enq_i)
            queue[qwptr] <= enq_idx_i;
        if (rd_valid_i)
            out_data_o <= rd_data_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qwptr  <= '0;
            qrptr  <= '0;
            qcount <= '0;
        end else begin
            if (enq_i)
                qwptr <= qwptr + 1'b1;
            // head index leaves as soon as its read is granted
            if (rd_gnt_i)
                qrptr <= qrptr + 1'b1;
            qcount <= qcount + enq_i - rd_gnt_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= ($clog2(OUT_CREDITS+1))'(OUT_CREDITS);
        end else begin
            // spent at grant, returned by the sink
            credits <= credits - rd_gnt_i + out_credit_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= rd_valid_i;
        end
    end

endmodule

// File: source/block_store.sv
// shared block memory with registered read and a fifo free list of block indices

`timescale 1ns/100ps

module block_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc_req_i,
    input  logic                           we_i,
    input  logic [mem_pkg::ADDR_W-1:0]     waddr_i,
    input  logic [mem_pkg::BLOCK_BITS-1:0] wdata_i,
    input  logic                           re_i,
    input  logic [mem_pkg::ADDR_W-1:0]     raddr_i,
    output logic                           alloc_gnt_o,
    output logic [mem_pkg::ADDR_W-1:0]     alloc_idx_o,
    output logic                           rvalid_o,
    output logic [mem_pkg::BLOCK_BITS-1:0] rdata_o
);
    import mem_pkg::*;

    logic [BLOCK_BITS-1:0] mem [NUM_BLOCKS];

    // free list storage and pointers
    logic [ADDR_W-1:0] free_idx [NUM_BLOCKS];
    logic [ADDR_W-1:0] head;
    logic [ADDR_W-1:0] tail;
    logic [ADDR_W:0]   free_cnt;

    assign alloc_gnt_o = alloc_req_i && (free_cnt != 0);
    assign alloc_idx_o = free_idx[head];

    always_ff @(posedge clk) begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        if (re_i)
            rdata_o <= mem[raddr_i];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= re_i;
        end
    end

    // every index starts out free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_BLOCKS; i++)
                free_idx[i] <= ADDR_W'(i);
            head     <= '0;
            tail     <= '0;
            free_cnt <= (ADDR_W+1)'(NUM_BLOCKS);
        end else begin
            if (alloc_gnt_o)
                head <= head + 1'b1;
            // a read releases its block at once
            if (re_i) begin
                free_idx[tail] <= raddr_i;
                tail           <= tail + 1'b1;
            end
            free_cnt <= free_cnt + re_i - alloc_gnt_o;
        end
    end

endmodule

// File: source/buffer_arbiter.sv
// write slot, in-order allocation and read arbitration for the shared block memory

`timescale 1ns/100ps

module buffer_arbiter (
    input  logic clk,
    input  logic rst_n,
    // writers
    input  logic                           alloc_req_i [switch_pkg::NUM_PORTS-1:0],
    input  logic                           wr_en_i     [switch_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::ADDR_W-1:0]     wr_addr_i   [switch_pkg::NUM_PORTS-1:0],
    input  logic [switch_pkg::PORT_W-1:0]  wr_dest_i   [switch_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::BLOCK_BITS-1:0] wr_data_i   [switch_pkg::NUM_PORTS-1:0],
    output logic                           alloc_gnt_o [switch_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::ADDR_W-1:0]     alloc_idx_o [switch_pkg::NUM_PORTS-1:0],
    output logic                           wr_gnt_o    [switch_pkg::NUM_PORTS-1:0],
    // readers
    input  logic                           rd_req_i    [switch_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::ADDR_W-1:0]     rd_addr_i   [switch_pkg::NUM_PORTS-1:0],
    output logic                           rd_gnt_o    [switch_pkg::NUM_PORTS-1:0],
    output logic                           rd_valid_o  [switch_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::BLOCK_BITS-1:0] rd_data_o   [switch_pkg::NUM_PORTS-1:0],
    output logic                           enq_o       [switch_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::ADDR_W-1:0]     enq_idx_o   [switch_pkg::NUM_PORTS-1:0],
    // block store
    output logic                           st_alloc_req_o,
    output logic                           st_we_o,
    output logic [mem_pkg::ADDR_W-1:0]     st_waddr_o,
    output logic [mem_pkg::BLOCK_BITS-1:0] st_wdata_o,
    output logic                           st_re_o,
    output logic [mem_pkg::ADDR_W-1:0]     st_raddr_o,
    input  logic                           st_alloc_gnt_i,
    input  logic [mem_pkg::ADDR_W-1:0]     st_alloc_idx_i,
    input  logic                           st_rvalid_i,
    input  logic [mem_pkg::BLOCK_BITS-1:0] st_rdata_i
);
    import switch_pkg::*;

    logic [PORT_W-1:0] wr_slot;
    logic [PORT_W-1:0] alloc_ptr;
    logic [PORT_W-1:0] rd_ptr;
    // port that owns the read currently in the store's output register
    logic [PORT_W-1:0] rd_port_q;

    // only the pointed-at port reaches each memory port
    assign st_we_o        = wr_en_i[wr_slot];
    assign st_waddr_o     = wr_addr_i[wr_slot];
    assign st_wdata_o     = wr_data_i[wr_slot];
    assign st_alloc_req_o = alloc_req_i[alloc_ptr];
    assign st_re_o        = rd_req_i[rd_ptr];
    assign st_raddr_o     = rd_addr_i[rd_ptr];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            wr_gnt_o[p]    = (wr_slot == PORT_W'(p));
            alloc_gnt_o[p] = st_alloc_gnt_i && (alloc_ptr == PORT_W'(p));
            alloc_idx_o[p] = st_alloc_idx_i;
            rd_gnt_o[p]    = st_re_o && (rd_ptr == PORT_W'(p));
            rd_valid_o[p]  = st_rvalid_i && (rd_port_q == PORT_W'(p));
            rd_data_o[p]   = st_rdata_i;
            // a written block is queued for its destination in the same cycle
            enq_o[p]       = st_we_o && (wr_dest_i[wr_slot] == PORT_W'(p));
            enq_idx_o[p]   = st_waddr_o;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_slot   <= '0;
            alloc_ptr <= '0;
            rd_ptr    <= '0;
            rd_port_q <= '0;
        end else begin
            wr_slot <= wr_slot + 1'b1;
            // allocations are served strictly in pointer order
            if (st_alloc_gnt_i || !alloc_req_i[alloc_ptr])
                alloc_ptr <= alloc_ptr + 1'b1;
            if (st_re_o)
                rd_port_q <= rd_ptr;
            else
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: source/port_writer.sv
// ingress fifo with credit return, block allocation and shared memory write

`timescale 1ns/100ps

module port_writer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid_i,
    input  logic [switch_pkg::PORT_W-1:0] in_dest_i,
    input  logic [mem_pkg::BLOCK_BITS-1:0] in_data_i,
    input  logic                          alloc_gnt_i,
    input  logic [mem_pkg::ADDR_W-1:0]    alloc_idx_i,
    input  logic                          wr_gnt_i,
    output logic                          in_credit_o,
    output logic                          alloc_req_o,
    output logic                          wr_en_o,
    output logic [mem_pkg::ADDR_W-1:0]    wr_addr_o,
    output logic [switch_pkg::PORT_W-1:0] wr_dest_o,
    output logic [mem_pkg::BLOCK_BITS-1:0] wr_data_o
);
    import switch_pkg::*;
    import mem_pkg::*;

    // fifo storage, payload only
    logic [BLOCK_BITS-1:0] data_mem [IN_FIFO_DEPTH];
    logic [PORT_W-1:0]     dest_mem [IN_FIFO_DEPTH];

    logic [$clog2(IN_FIFO_DEPTH)-1:0]   wptr;
    logic [$clog2(IN_FIFO_DEPTH)-1:0]   rptr;
    logic [$clog2(IN_FIFO_DEPTH+1)-1:0] count;

    writer_state_e     state;
    logic [ADDR_W-1:0] idx_q;
    logic              pop;

    // head leaves the fifo once its slot has been used
    assign pop = (state == W_WRITE) && wr_gnt_i;

    assign alloc_req_o = (state == W_ALLOC);
    assign wr_en_o     = (state == W_WRITE);
    assign wr_addr_o   = idx_q;
    assign wr_dest_o   = dest_mem[rptr];
    assign wr_data_o   = data_mem[rptr];

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            data_mem[wptr] <= in_data_i;
            dest_mem[wptr] <= in_dest_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr        <= '0;
            rptr        <= '0;
            count       <= '0;
            in_credit_o <= 1'b0;
        end else begin
            // source only sends while holding a credit, so no full check
            if (in_valid_i)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            count       <= count + in_valid_i - pop;
            in_credit_o <= pop;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= W_IDLE;
            idx_q <= '0;
        end else begin
            case (state)
                W_IDLE:  if (count != 0) state <= W_ALLOC;
                W_ALLOC: if (alloc_gnt_i) begin
                    idx_q <= alloc_idx_i;
                    state <= W_WRITE;
                end
                W_WRITE: if (wr_gnt_i) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

// File: source/switch_pkg.sv
// switch port count, credit depths and writer state type

package switch_pkg;

    // number of switch ports
    localparam int NUM_PORTS = 4;

    // width of a port index
    localparam int PORT_W = $clog2(NUM_PORTS);

    // ingress fifo depth, also the initial credit count of the source
    localparam int IN_FIFO_DEPTH = 4;

    // egress credits a reader holds after reset
    localparam int OUT_CREDITS = 2;

    // port writer states
    typedef enum logic [1:0] {
        W_IDLE,
        W_ALLOC,
        W_WRITE
    } writer_state_e;

endpackage

// File: source/mem_pkg.sv
// shared block memory and free list sizing constants

package mem_pkg;

    // data width of one block
    localparam int BLOCK_BITS = 32;

    // number of blocks held in the shared memory
    localparam int NUM_BLOCKS = 8;

    // width of a block index
    localparam int ADDR_W = $clog2(NUM_BLOCKS);

endpackage
